// File: compile.f
+incdir+testbench
rtl/aluPkg.sv
rtl/claAdder16.sv
rtl/subwordAdder.sv
rtl/reductionUnit.sv
rtl/barrelShifter.sv
rtl/alu.sv
rtl/resultFlagRegister.sv
rtl/aluExecute.sv
testbench/aluExecuteTb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the ALU execute testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module aluExecuteTb -o aluExecuteTb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/aluExecuteTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
  exit 0
fi
exit 1

// File: testbench/aluModel.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

////////////////////////////////////////
// Reference behavior from the ISA rules
////////////////////////////////////////

// C to F have no operation
function automatic logic isIllegal(aluOpcodeT op);
  return op >= 4'hC;
endfunction

// Clamp a signed integer into the range of a 16-bit word
function automatic logic [15:0] clampWord(int value);
  int clamped;
  clamped = value;
  if (clamped > 32767) clamped = 32767;
  else if (clamped < -32768) clamped = -32768;
  return clamped[15:0];
endfunction

// True sum or difference of the signed operands
function automatic int exactSum(aluOpcodeT op, logic [15:0] a, logic [15:0] b);
  if (op == OpSub) return int'($signed(a)) - int'($signed(b));
  return int'($signed(a)) + int'($signed(b));
endfunction

function automatic logic [15:0] expectedData(aluOpcodeT op, logic [15:0] a, logic [15:0] b);
  logic [15:0] data;
  logic [31:0] doubled;  // a twice over, for the rotate
  int          lane;
  data = '0;
  case (op)
    OpAdd, OpSub: data = clampWord(exactSum(op, a, b));
    OpXor:        data = a ^ b;
    OpRed:        data = 16'(int'($signed(a[15:8])) + int'($signed(a[7:0]))
                       + int'($signed(b[15:8])) + int'($signed(b[7:0])));
    OpSll:        data = a << b[3:0];
    OpSra:        data = $signed(a) >>> b[3:0];
    OpRor: begin
      doubled = {a, a} >> b[3:0];
      data    = doubled[15:0];
    end
    OpPaddsb: begin
      for (int i = 0; i < 4; i++) begin
        lane = int'($signed(a[4*i +: 4])) + int'($signed(b[4*i +: 4]));
        if (lane > 7) lane = 7;  // Lane clamps on its own
        else if (lane < -8) lane = -8;
        data[4*i +: 4] = lane[3:0];
      end
    end
    OpLw, OpSw:   data = (a & 16'hFFFE) + {b[14:0], 1'b0};  // Wraps, word offset
    OpLlb:        data = {a[15:8], b[7:0]};
    OpLhb:        data = {b[7:0], a[7:0]};
    default:      data = '0;
  endcase
  return data;
endfunction

// Flags after one legal operation, only the masked ones move
function automatic aluFlagsT nextFlags(aluOpcodeT op, logic [15:0] a, logic [15:0] b,
                                       aluFlagsT prev);
  aluFlagsT    upd;
  logic [15:0] data;
  int          exact;
  data  = expectedData(op, a, b);
  exact = exactSum(op, a, b);
  upd   = prev;
  case (op)
    OpAdd, OpSub: begin
      upd.z = (data == '0);
      upd.v = (exact > 32767) || (exact < -32768);
      upd.n = data[15];
    end
    OpXor, OpSll, OpSra, OpRor: upd.z = (data == '0);
    default: upd = prev;
  endcase
  return upd;
endfunction

`endif

// File: testbench/aluExecuteTb.sv
`timescale 1ns/1ps
`default_nettype none

module aluExecuteTb;

  import aluPkg::*;

  `include "aluModel.svh"

  localparam int DoneTimeout = 20;  // Cycles to wait for done

  logic                 clk;
  logic                 reset;
  logic                 issue;
  aluOpcodeT            opcode;
  logic [DataWidth-1:0] operandA;
  logic [DataWidth-1:0] operandB;
  logic [DataWidth-1:0] result;
  aluFlagsT             flags;
  logic                 done;
  logic                 illegal;

  logic [DataWidth-1:0] expResult;  // Shadow of the register stage
  aluFlagsT             expFlags;
  logic                 expDone;
  logic                 expIllegal;
  int                   seed;
  int                   errorCount;
  int                   testCount;

  aluExecute i_dut (
    .clk      (clk),
    .reset    (reset),
    .issue    (issue),
    .opcode   (opcode),
    .operandA (operandA),
    .operandB (operandB),
    .result   (result),
    .flags    (flags),
    .done     (done),
    .illegal  (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // Expected outputs, one cycle behind the issued operation
  always @(posedge clk) begin
    if (reset) begin
      expResult  <= '0;
      expFlags   <= '0;
      expDone    <= 1'b0;
      expIllegal <= 1'b0;
    end else begin
      expDone    <= issue;
      expIllegal <= issue && isIllegal(opcode);
      if (issue && !isIllegal(opcode)) begin
        expResult <= expectedData(opcode, operandA, operandB);
        expFlags  <= nextFlags(opcode, operandA, operandB, expFlags);
      end
    end
  end

  ////////////////////////////////////////
  // Checks on every cycle
  ////////////////////////////////////////
  assert property (@(posedge clk) disable iff (reset) result == expResult)
    else begin
      $display("Mismatch at %0t: result %h, expected %h", $time, $sampled(result),
               $sampled(expResult));
      errorCount++;
    end
  assert property (@(posedge clk) disable iff (reset) flags == expFlags)
    else begin
      $display("Mismatch at %0t: flags ZVN %b, expected %b", $time, $sampled(flags),
               $sampled(expFlags));
      errorCount++;
    end
  assert property (@(posedge clk) disable iff (reset) done == expDone)
    else begin
      $display("Mismatch at %0t: done %b, expected %b", $time, $sampled(done),
               $sampled(expDone));
      errorCount++;
    end
  assert property (@(posedge clk) disable iff (reset) illegal == expIllegal)
    else begin
      $display("Mismatch at %0t: illegal %b, expected %b", $time, $sampled(illegal),
               $sampled(expIllegal));
      errorCount++;
    end

  function automatic logic [15:0] randomWord();
    logic [31:0] raw;
    raw = $random(seed);
    return raw[15:0];
  endfunction

  // Polls at the falling edge where outputs are settled
  task automatic waitDone();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!done && cycles < DoneTimeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) begin
      $display("Timeout at %0t: done never rose after issue", $time);
      $display("** FAIL **");
      $finish;
    end
  endtask

  task automatic runOp(input aluOpcodeT op, input logic [15:0] a, input logic [15:0] b);
    @(posedge clk);
    issue    <= 1'b1;
    opcode   <= op;
    operandA <= a;
    operandB <= b;
    @(posedge clk);
    issue <= 1'b0;
    waitDone();
  endtask

  // Issue held high, a new random operation every cycle
  task automatic runBurst(input int count);
    logic [15:0] pick;
    for (int i = 0; i < count; i++) begin
      pick = randomWord();
      @(posedge clk);
      issue    <= 1'b1;
      opcode   <= aluOpcodeT'(pick[3:0]);  // Illegal codes included
      operandA <= randomWord();
      operandB <= randomWord();
    end
    @(posedge clk);
    issue <= 1'b0;
    waitDone();
  endtask

  task automatic finishTest(input string name);
    testCount++;
    $display("Test %s finished, %0d errors so far", name, errorCount);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    seed       = 46;
    errorCount = 0;
    testCount  = 0;
    reset      = 1'b1;
    issue      = 1'b0;
    opcode     = OpAdd;
    operandA   = '0;
    operandB   = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    @(negedge clk);
    assert (!done && !illegal && result == '0 && flags == '0)
      else begin
        $display("Mismatch at %0t: outputs not cleared by reset", $time);
        errorCount++;
      end
    finishTest("reset");

    runOp(OpAdd, 16'h7FFF, 16'h0001);  // Positive saturation
    runOp(OpAdd, 16'h8000, 16'hFFFF);  // Negative saturation
    runOp(OpSub, 16'h8000, 16'h0001);
    runOp(OpSub, 16'h7FFF, 16'hFFFF);
    runOp(OpSub, 16'h1234, 16'h1234);  // Zero result
    runOp(OpAdd, 16'hFFFF, 16'h0001);  // Wraps to zero, no overflow
    for (int i = 0; i < 20; i++) begin
      runOp(OpAdd, randomWord(), randomWord());
      runOp(OpSub, randomWord(), randomWord());
    end
    finishTest("add/sub");

    runOp(OpAdd, 16'h8000, 16'hFFFF);  // Leaves V and N set
    for (int i = 0; i < 8; i++) runOp(OpXor, randomWord(), randomWord());
    runOp(OpXor, 16'hA5A5, 16'hA5A5);
    for (int amt = 0; amt < 16; amt++) begin
      runOp(OpSll, randomWord(), {randomWord() & 16'hFFF0} | 16'(amt[3:0]));
      runOp(OpSra, randomWord(), 16'(amt[3:0]));
      runOp(OpRor, randomWord(), 16'(amt[3:0]));
    end
    finishTest("logic/shift");

    runOp(OpSub, 16'h7FFF, 16'hFFFF);  // V set, N clear
    for (int i = 0; i < 8; i++) begin
      runOp(OpRed, randomWord(), randomWord());
      runOp(OpPaddsb, randomWord(), randomWord());
      runOp(OpLw, randomWord(), randomWord());
      runOp(OpSw, randomWord(), randomWord());
      runOp(OpLlb, randomWord(), randomWord());
      runOp(OpLhb, randomWord(), randomWord());
    end
    runOp(OpPaddsb, 16'h7777, 16'h1111);  // Every lane clamps high
    runOp(OpPaddsb, 16'h8888, 16'h8888);  // Every lane clamps low
    runOp(OpRed, 16'h8080, 16'h8080);     // Most negative reduction
    finishTest("sub-word/load");

    for (int code = 12; code < 16; code++) begin
      runOp(aluOpcodeT'(code[3:0]), randomWord(), randomWord());
    end
    finishTest("illegal");

    runBurst(32);
    finishTest("back-to-back");

    repeat (2) @(posedge clk);
    @(negedge clk);
    $display("Tests run: %0d, errors: %0d", testCount, errorCount);
    if (errorCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/aluExecute.sv
`timescale 1ns/1ps
`default_nettype none

module aluExecute (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          issue,
  input  wire  aluPkg::aluOpcodeT       opcode,
  input  wire  [aluPkg::DataWidth-1:0] operandA,
  input  wire  [aluPkg::DataWidth-1:0] operandB,
  output logic [aluPkg::DataWidth-1:0] result,
  output aluPkg::aluFlagsT             flags,
  output logic                         done,
  output logic                         illegal
);

  import aluPkg::*;

  aluResultT aluOut;  // Combinational ALU output into the register stage

  alu iAlu (
    .opcode   (opcode),
    .operandA (operandA),
    .operandB (operandB),
    .aluOut   (aluOut)
  );

  // Results appear one cycle after issue
  resultFlagRegister iResultReg (
    .clk     (clk),
    .reset   (reset),
    .issue   (issue),
    .aluOut  (aluOut),
    .result  (result),
    .flags   (flags),
    .done    (done),
    .illegal (illegal)
  );

endmodule

`default_nettype wire

// File: rtl/resultFlagRegister.sv
`timescale 1ns/1ps
`default_nettype none

module resultFlagRegister (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          issue,    // One operation per high cycle
  input  wire  aluPkg::aluResultT       aluOut,
  output logic [aluPkg::DataWidth-1:0] result,
  output aluPkg::aluFlagsT             flags,
  output logic                         done,     // Cycle after issue
  output logic                         illegal   // Pulses with done
);

  logic capture;  // Legal operation this cycle

  assign capture = issue && !aluOut.illegal;

  ////////////////////////////////////////
  // Result, flags and strobes
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      result  <= '0;
      flags   <= '0;
      done    <= 1'b0;
      illegal <= 1'b0;
    end else begin
      done    <= issue;
      illegal <= issue && aluOut.illegal;
      if (capture) begin
        result <= aluOut.data;
        // Per-flag write enables
        if (aluOut.mask.updZ) flags.z <= aluOut.flags.z;
        if (aluOut.mask.updV) flags.v <= aluOut.flags.v;
        if (aluOut.mask.updN) flags.n <= aluOut.flags.n;
      end
    end
  end

  // done only in the cycle after an issue
  assert property (@(posedge clk) disable iff (reset) !issue |=> !done)
    else $error("done without a preceding issue");

  // Flags only move on an issued operation
  assert property (@(posedge clk) disable iff (reset) !issue |=> $stable(flags))
    else $error("Flags changed without issue");

endmodule

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire  aluPkg::aluOpcodeT        opcode,
  input  wire  [aluPkg::DataWidth-1:0]   operandA,
  input  wire  [aluPkg::DataWidth-1:0]   operandB,
  output aluPkg::aluResultT              aluOut
);

  import aluPkg::*;

  logic                 isMem;         // LW or SW address generation
  logic [DataWidth-1:0] adderA;
  logic [DataWidth-1:0] adderB;
  logic                 adderSub;
  logic [DataWidth-1:0] adderSum;
  logic                 adderOvfl;
  logic [DataWidth-1:0] satSum;        // ADD/SUB after clamping
  logic [DataWidth-1:0] subwordSum;
  logic [DataWidth-1:0] reductionSum;
  logic [DataWidth-1:0] shiftResult;
  logic [DataWidth-1:0] resultData;
  aluFlagMaskT          resultMask;
  logic                 resultIllegal;

  ////////////////////////////////////////
  // Adder and sub-units
  ////////////////////////////////////////
  assign isMem    = (opcode == OpLw) || (opcode == OpSw);
  assign adderA   = isMem ? {operandA[DataWidth-1:1], 1'b0} : operandA;  // Word aligned base
  assign adderB   = isMem ? {operandB[DataWidth-2:0], 1'b0} : operandB;  // Word offset
  assign adderSub = (opcode == OpSub);

  claAdder16 iAdder (
    .a    (adderA),
    .b    (adderB),
    .sub  (adderSub),
    .sum  (adderSum),
    .ovfl (adderOvfl)
  );

  subwordAdder iSubword (
    .a   (operandA),
    .b   (operandB),
    .sum (subwordSum)
  );

  reductionUnit iReduction (
    .a   (operandA),
    .b   (operandB),
    .sum (reductionSum)
  );

  barrelShifter iShifter (
    .shiftIn     (operandA),
    .mode        (opcode),
    .shiftAmount (operandB[ShiftWidth-1:0]),  // Low nibble of B is the amount
    .shiftOut    (shiftResult)
  );

  // Overflow direction follows the sign of A for both add and subtract
  assign satSum = !adderOvfl       ? adderSum :
                  adderA[DataWidth-1] ? {1'b1, {(DataWidth-1){1'b0}}}
                                      : {1'b0, {(DataWidth-1){1'b1}}};

  ////////////////////////////////////////
  // Opcode select
  ////////////////////////////////////////
  always_comb begin
    resultData    = '0;
    resultMask    = '0;  // Most operations leave the flags alone
    resultIllegal = 1'b0;
    case (opcode)
      OpAdd, OpSub: begin
        resultData = satSum;
        resultMask = '{updZ: 1'b1, updV: 1'b1, updN: 1'b1};
      end
      OpXor: begin
        resultData = operandA ^ operandB;
        resultMask = '{updZ: 1'b1, updV: 1'b0, updN: 1'b0};
      end
      OpSll, OpSra, OpRor: begin
        resultData = shiftResult;
        resultMask = '{updZ: 1'b1, updV: 1'b0, updN: 1'b0};
      end
      OpRed:      resultData = reductionSum;
      OpPaddsb:   resultData = subwordSum;
      OpLw, OpSw: resultData = adderSum;  // Addresses wrap, no clamping
      OpLlb:      resultData = {operandA[DataWidth-1:8], operandB[7:0]};
      OpLhb:      resultData = {operandB[7:0], operandA[7:0]};
      default:    resultIllegal = 1'b1;  // C to F
    endcase
  end

  assign aluOut = '{
    data:    resultData,
    flags:   '{z: (resultData == '0), v: adderOvfl, n: resultData[DataWidth-1]},
    mask:    resultMask,
    illegal: resultIllegal
  };

  // Mask rules relied on by the flag register
  always_comb begin
    assert (!resultMask.updV || resultMask.updZ)
      else $error("V flag update without Z flag update");
    assert (!resultIllegal || (resultMask == '0))
      else $error("Illegal opcode with a non-empty flag mask");
  end

endmodule

`default_nettype wire

// File: rtl/barrelShifter.sv
`timescale 1ns/1ps
`default_nettype none

module barrelShifter (
  input  wire  [aluPkg::DataWidth-1:0]  shiftIn,
  input  wire  aluPkg::aluOpcodeT        mode,         // OpSll, OpSra or OpRor
  input  wire  [aluPkg::ShiftWidth-1:0] shiftAmount,
  output logic [aluPkg::DataWidth-1:0]  shiftOut
);

  import aluPkg::*;

  ////////////////////////////////////////
  // Shift by 1, 2, 4 and 8
  ////////////////////////////////////////
  for (genvar stage = 0; stage < ShiftWidth; stage++) begin : gStage
    localparam int Dist = 1 << stage;

    logic [DataWidth-1:0] stageIn;
    logic [DataWidth-1:0] stageOut;  // Value after the low stage+1 amount bits
    logic [DataWidth-1:0] leftOut;   // Zero fill from the right
    logic [DataWidth-1:0] arithOut;  // Sign fill from the left
    logic [DataWidth-1:0] rotOut;    // Low bits wrap to the top

    if (stage == 0) begin : gFirst
      assign stageIn = shiftIn;
    end else begin : gChain
      assign stageIn = gStage[stage-1].stageOut;  // Output of the previous stage
    end

    assign leftOut  = {stageIn[DataWidth-1-Dist:0], {Dist{1'b0}}};
    assign arithOut = {{Dist{stageIn[DataWidth-1]}}, stageIn[DataWidth-1:Dist]};
    assign rotOut   = {stageIn[Dist-1:0], stageIn[DataWidth-1:Dist]};

    always_comb begin
      if (!shiftAmount[stage]) begin
        stageOut = stageIn;  // Bypass this stage
      end else begin
        case (mode)
          OpSra:   stageOut = arithOut;
          OpRor:   stageOut = rotOut;
          default: stageOut = leftOut;  // OpSll
        endcase
      end
    end
  end

  assign shiftOut = gStage[ShiftWidth-1].stageOut;

endmodule

`default_nettype wire

// File: rtl/reductionUnit.sv
`timescale 1ns/1ps
`default_nettype none

module reductionUnit (
  input  wire  [aluPkg::DataWidth-1:0] a,
  input  wire  [aluPkg::DataWidth-1:0] b,
  output logic [aluPkg::DataWidth-1:0] sum
);

  import aluPkg::*;

  logic signed [7:0] aHigh;
  logic signed [7:0] aLow;
  logic signed [7:0] bHigh;
  logic signed [7:0] bLow;
  logic signed [8:0] highSum;  // First level needs one extra bit
  logic signed [8:0] lowSum;
  logic signed [9:0] total;    // Four bytes fit in 10 bits

  assign aHigh = a[15:8];
  assign aLow  = a[7:0];
  assign bHigh = b[15:8];
  assign bLow  = b[7:0];

  ////////////////////////////////////////
  // Two-level adder tree
  ////////////////////////////////////////
  assign highSum = {aHigh[7], aHigh} + {bHigh[7], bHigh};  // Both bytes sign-extended
  assign lowSum  = {aLow[7], aLow} + {bLow[7], bLow};
  assign total   = {highSum[8], highSum} + {lowSum[8], lowSum};

  assign sum = {{(DataWidth-10){total[9]}}, total};  // Sign-extend to the full word

endmodule

`default_nettype wire

// File: rtl/subwordAdder.sv
`timescale 1ns/1ps
`default_nettype none

module subwordAdder (
  input  wire  [aluPkg::DataWidth-1:0] a,
  input  wire  [aluPkg::DataWidth-1:0] b,
  output logic [aluPkg::DataWidth-1:0] sum
);

  import aluPkg::*;

  localparam int LaneWidth = 4;
  localparam int LaneCount = DataWidth / LaneWidth;

  ////////////////////////////////////////
  // Independent signed nibble lanes
  ////////////////////////////////////////
  for (genvar lane = 0; lane < LaneCount; lane++) begin : gLane
    localparam int Base = LaneWidth * lane;

    logic [LaneWidth-1:0] rawSum;   // Wrapping lane sum
    logic                 aSign;
    logic                 bSign;
    logic                 laneOvfl;

    assign aSign  = a[Base+LaneWidth-1];
    assign bSign  = b[Base+LaneWidth-1];
    assign rawSum = a[Base +: LaneWidth] + b[Base +: LaneWidth];  // No carry between lanes

    // Same input signs but the sum flipped sign
    assign laneOvfl = (aSign == bSign) && (rawSum[LaneWidth-1] != aSign);

    // Clamp to +7 or -8 in the direction of the inputs
    always_comb begin
      if (!laneOvfl) begin
        sum[Base +: LaneWidth] = rawSum;
      end else if (aSign) begin
        sum[Base +: LaneWidth] = 4'h8;  // Most negative nibble
      end else begin
        sum[Base +: LaneWidth] = 4'h7;  // Most positive nibble
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/claAdder16.sv
`timescale 1ns/1ps
`default_nettype none

module claAdder16 (
  input  wire  [aluPkg::DataWidth-1:0] a,
  input  wire  [aluPkg::DataWidth-1:0] b,
  input  wire                          sub,   // High selects a - b
  output logic [aluPkg::DataWidth-1:0] sum,
  output logic                         ovfl   // Signed overflow
);

  import aluPkg::*;

  localparam int GroupCount = DataWidth / 4;

  logic [DataWidth-1:0]  bEff;        // b, inverted for subtract
  logic [DataWidth-1:0]  prop;        // Bit propagate
  logic [DataWidth-1:0]  gen;         // Bit generate
  logic [DataWidth-1:0]  carry;       // Carry into each bit
  logic [GroupCount-2:0] groupP;      // Top group has no carry out to feed
  logic [GroupCount-2:0] groupG;
  logic [GroupCount-1:0] groupCarry;  // Carry into each 4-bit group

  assign bEff = b ^ {DataWidth{sub}};  // Two's complement with carry-in below
  assign prop = a ^ bEff;
  assign gen  = a & bEff;

  ////////////////////////////////////////
  // First level, group propagate/generate
  ////////////////////////////////////////
  for (genvar grp = 0; grp < GroupCount - 1; grp++) begin : gGroupPg
    localparam int Base = 4 * grp;

    assign groupP[grp] = &prop[Base +: 4];
    assign groupG[grp] = gen[Base+3]
                       | prop[Base+3] & gen[Base+2]
                       | prop[Base+3] & prop[Base+2] & gen[Base+1]
                       | prop[Base+3] & prop[Base+2] & prop[Base+1] & gen[Base];
  end

  ////////////////////////////////////////
  // Second level, group carries
  ////////////////////////////////////////
  assign groupCarry[0] = sub;  // Carry-in of 1 completes the negation
  assign groupCarry[1] = groupG[0] | groupP[0] & sub;
  assign groupCarry[2] = groupG[1]
                       | groupP[1] & groupG[0]
                       | groupP[1] & groupP[0] & sub;
  assign groupCarry[3] = groupG[2]
                       | groupP[2] & groupG[1]
                       | groupP[2] & groupP[1] & groupG[0]
                       | groupP[2] & groupP[1] & groupP[0] & sub;

  // Bit carries inside each group, all from the group carry-in
  for (genvar grp = 0; grp < GroupCount; grp++) begin : gBitCarry
    localparam int Base = 4 * grp;

    assign carry[Base]   = groupCarry[grp];
    assign carry[Base+1] = gen[Base] | prop[Base] & groupCarry[grp];
    assign carry[Base+2] = gen[Base+1]
                         | prop[Base+1] & gen[Base]
                         | prop[Base+1] & prop[Base] & groupCarry[grp];
    assign carry[Base+3] = gen[Base+2]
                         | prop[Base+2] & gen[Base+1]
                         | prop[Base+2] & prop[Base+1] & gen[Base]
                         | prop[Base+2] & prop[Base+1] & prop[Base] & groupCarry[grp];
  end

  assign sum = prop ^ carry;

  // Both operands negative with positive sum, or both positive with negative sum
  assign ovfl = gen[DataWidth-1] & ~sum[DataWidth-1]
              | ~(prop[DataWidth-1] | gen[DataWidth-1]) & sum[DataWidth-1];

endmodule

`default_nettype wire

// File: rtl/aluPkg.sv
`default_nettype none

package aluPkg;

  ////////////////////////////////////////
  // Widths fixed by the ISA
  ////////////////////////////////////////
  localparam int DataWidth  = 16;  // Every data port and register
  localparam int ShiftWidth = 4;   // Shift amount field, 0 to 15 places

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////
  // Encodings C to F are not named and are treated as illegal
  typedef enum logic [3:0] {
    OpAdd    = 4'h0,  // Saturating add
    OpSub    = 4'h1,  // Saturating subtract
    OpXor    = 4'h2,
    OpRed    = 4'h3,  // Signed byte reduction
    OpSll    = 4'h4,
    OpSra    = 4'h5,
    OpRor    = 4'h6,
    OpPaddsb = 4'h7,  // Four saturating nibble lanes
    OpLw     = 4'h8,  // Address generation
    OpSw     = 4'h9,  // Address generation
    OpLlb    = 4'hA,  // Load low byte
    OpLhb    = 4'hB   // Load high byte
  } aluOpcodeT;

  ////////////////////////////////////////
  // Flags and result bundle
  ////////////////////////////////////////
  typedef struct packed {
    logic z;  // Result is zero
    logic v;  // Signed overflow from the adder
    logic n;  // Result bit 15
  } aluFlagsT;

  // One write enable per flag
  typedef struct packed {
    logic updZ;
    logic updV;
    logic updN;
  } aluFlagMaskT;

  // Everything the register stage needs from the ALU
  typedef struct packed {
    logic [DataWidth-1:0] data;
    aluFlagsT             flags;
    aluFlagMaskT          mask;
    logic                 illegal;  // Opcode C to F
  } aluResultT;

endpackage

`default_nettype wire
